// File: project.f
source/soc_ifc_pkg.sv
source/soc_ifc_boot_fsm.sv
source/soc_ifc_reg_block.sv
source/soc_ifc_fuse_bank.sv
source/soc_ifc_top.sv
tests/soc_ifc_tb.sv

// File: tests/soc_ifc_tb.sv
/* soc interface testbench: clock, reset, bus tasks, boot and firmware-update
   reset stimulus, reference model, assertions and watchdog */

`timescale 1ns/10ps
`default_nettype none

module soc_ifc_tb;

    import soc_ifc_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int FUSE_WORDS   = 8;
    // each bus access spans two cycles
    localparam int BUS_CYCLES   = 2;
    localparam int MAX_BUS_OPS  = 256;
    // all firmware reset waits plus release latency of each run
    localparam int FW_WAIT_CYCLES  = 6 + 3 + 1 + 6 + 256 + 5 * 4;
    localparam int WATCHDOG_CYCLES =
        2 * (RESET_CYCLES + BUS_CYCLES * MAX_BUS_OPS + FW_WAIT_CYCLES);

    // what happens to the iccm lock around a firmware reset
    localparam int MODE_LOCK_FIRST = 0;
    localparam int MODE_RELOCK     = 1;
    localparam int MODE_POLL       = 2;

    logic                        clk;
    logic                        cptra_rst_b;
    logic                        cptra_pwrgood;
    soc_ifc_req_t                req;
    soc_ifc_rsp_t                rsp;
    logic                        ready_for_fuses;
    logic                        cptra_noncore_rst_b;
    logic                        cptra_uc_rst_b;
    logic                        iccm_unlock;
    logic                        iccm_lock;
    logic [FUSE_WORDS-1:0][31:0] fuse_words;
    boot_fsm_state_e             fsm_state;

    // reference model
    logic [31:0] exp_fuse [FUSE_WORDS];
    logic        exp_fuse_done;
    logic [7:0]  exp_wait;
    logic        exp_lock;

    logic [31:0] lcg_state;

    soc_ifc_top soc_ifc_top_inst (
        .clk                 (clk),
        .cptra_rst_b         (cptra_rst_b),
        .cptra_pwrgood       (cptra_pwrgood),
        .req                 (req),
        .rsp                 (rsp),
        .ready_for_fuses     (ready_for_fuses),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .cptra_uc_rst_b      (cptra_uc_rst_b),
        .iccm_unlock         (iccm_unlock),
        .iccm_lock           (iccm_lock),
        .fuse_words          (fuse_words)
    );

    assign fsm_state = soc_ifc_top_inst.boot_fsm_inst.state_ps;

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else report_error($sformatf("Fail %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else report_error($sformatf("Fail %s: expected %h, got %h", name, exp, got));
    endtask

    task automatic check_state(input boot_fsm_state_e exp);
        assert (fsm_state === exp)
        else report_error($sformatf("Fail state_ps: expected %h (%s), got %h (%s)",
                                    exp, exp.name(), fsm_state, fsm_state.name()));
    endtask

    task automatic check_fuse_words();
        int i;
        for (i = 0; i < FUSE_WORDS; i++) begin
            check_value($sformatf("fuse_words[%0d]", i), fuse_words[i], exp_fuse[i]);
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] fuse_addr(input int idx);
        return REG_FUSE_BASE + 8'(idx * 4);
    endfunction

    // one request, response taken one cycle after it was sampled
    task automatic bus_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        soc_ifc_req_t r;
        r.valid = 1'b1;
        r.write = write;
        r.addr  = addr;
        r.wdata = wdata;
        @(posedge clk);
        req <= r;
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        check_bit("rsp.valid", rsp.valid, 1'b1);
        rdata = rsp.rdata;
        err   = rsp.err;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata,
                             input logic exp_err);
        logic [31:0] rd;
        logic        er;
        bus_access(1'b1, addr, wdata, rd, er);
        check_bit($sformatf("rsp.err (write %h)", addr), er, exp_err);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp_data);
        logic [31:0] rd;
        logic        er;
        bus_access(1'b0, addr, 32'd0, rd, er);
        check_bit($sformatf("rsp.err (read %h)", addr), er, 1'b0);
        check_value($sformatf("rsp.rdata (read %h)", addr), rd, exp_data);
    endtask

    // core held for wait+2 cycles, unlock at edge wait+1 after fw_rst entry
    task automatic run_fw_reset(input logic [7:0] wait_val, input bit write_wait,
                                input int mode);
        int n;
        int k;
        int j;
        // zero wraps the 8-bit counter
        n = (wait_val == 8'd0) ? 256 : int'(wait_val);
        if (write_wait) begin
            write_reg(REG_FW_RST_WAIT, {24'd0, wait_val}, 1'b0);
            exp_wait = wait_val;
        end
        read_reg(REG_FW_RST_WAIT, {24'd0, exp_wait});
        if (mode == MODE_LOCK_FIRST) begin
            write_reg(REG_ICCM_LOCK, 32'h1, 1'b0);
            exp_lock = 1'b1;
            read_reg(REG_ICCM_LOCK, {31'd0, exp_lock});
        end
        write_reg(REG_FW_UPDATE_RST, 32'h1, 1'b0);
        // pulse is high now, fsm takes it at the next edge
        check_state(BOOT_DONE);
        @(negedge clk);
        check_state(BOOT_FW_RST);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b1);
        fork
            begin
                for (k = 1; k <= n + 3; k++) begin
                    @(negedge clk);
                    check_bit("cptra_uc_rst_b", cptra_uc_rst_b, k >= n + 3);
                    check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b1);
                    check_bit("iccm_unlock", iccm_unlock, k == n + 1);
                    if (k == n + 1) begin
                        check_state(BOOT_DONE);
                    end
                    if (mode == MODE_LOCK_FIRST) begin
                        check_bit("iccm_lock", iccm_lock, k <= n + 1);
                    end
                end
            end
            begin
                if (mode == MODE_RELOCK) begin
                    // lock set while the core is held
                    write_reg(REG_ICCM_LOCK, 32'h1, 1'b0);
                    read_reg(REG_ICCM_LOCK, 32'h1);
                end else if (mode == MODE_POLL) begin
                    // access j sees the levels after edge 2j+1, across hold and release
                    for (j = 0; j < (n + 5) / 2; j++) begin
                        read_reg(REG_BOOT_STATUS,
                                 {29'd0, (2 * j + 1 >= n + 3), 1'b1, 1'b0});
                    end
                end
            end
        join
        exp_lock = 1'b0;
        check_bit("iccm_lock", iccm_lock, exp_lock);
        read_reg(REG_ICCM_LOCK, {31'd0, exp_lock});
        read_reg(REG_BOOT_STATUS, 32'h6);
    endtask

    // every request answered on the next cycle, and only then
    assert property (@(posedge clk) disable iff (!cptra_rst_b) req.valid |=> rsp.valid)
    else report_error($sformatf("Fail rsp.valid: expected %h, got %h", 1'b1, rsp.valid));

    assert property (@(posedge clk) disable iff (!cptra_rst_b) !req.valid |=> !rsp.valid)
    else report_error($sformatf("Fail rsp.valid: expected %h, got %h", 1'b0, rsp.valid));

    assert property (@(posedge clk) disable iff (!cptra_rst_b) !$fell(cptra_noncore_rst_b))
    else report_error($sformatf("Fail cptra_noncore_rst_b: expected %h, got %h",
                                1'b1, cptra_noncore_rst_b));

    assert property (@(posedge clk) disable iff (!cptra_rst_b) iccm_unlock |=> !iccm_unlock)
    else report_error($sformatf("Fail iccm_unlock: expected %h, got %h", 1'b0, iccm_unlock));

    // both resets held in idle and fuse
    assert property (@(posedge clk) disable iff (!cptra_rst_b)
        (fsm_state == BOOT_IDLE || ready_for_fuses) |-> !(cptra_noncore_rst_b | cptra_uc_rst_b))
    else report_error($sformatf("Fail reset outputs: expected 0/0, got %h/%h",
                                cptra_noncore_rst_b, cptra_uc_rst_b));

    initial begin
        int          i;
        logic [31:0] rd;
        logic        er;
        clk           = 1'b0;
        cptra_rst_b   = 1'b0;
        cptra_pwrgood = 1'b0;
        req           = '0;
        lcg_state     = 32'h971c;
        exp_fuse_done = 1'b0;
        exp_wait      = FW_RST_WAIT_RESET;
        exp_lock      = 1'b0;
        for (i = 0; i < FUSE_WORDS; i++) begin
            exp_fuse[i] = 32'd0;
        end

        repeat (RESET_CYCLES - 1) @(posedge clk);
        @(negedge clk);
        check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        check_bit("iccm_unlock", iccm_unlock, 1'b0);
        check_bit("iccm_lock", iccm_lock, 1'b0);
        check_bit("fw_update_rst", soc_ifc_top_inst.fw_update_rst, 1'b0);
        check_bit("rsp.valid", rsp.valid, 1'b0);
        check_state(BOOT_IDLE);
        @(posedge clk);
        cptra_rst_b <= 1'b1;

        // register reset values, still in idle
        read_reg(REG_FUSE_DONE, {31'd0, exp_fuse_done});
        read_reg(REG_FW_RST_WAIT, {24'd0, exp_wait});
        read_reg(REG_ICCM_LOCK, {31'd0, exp_lock});
        check_state(BOOT_IDLE);
        check_fuse_words();

        // power good sampled at the next edge
        @(posedge clk);
        cptra_pwrgood <= 1'b1;
        @(negedge clk);
        check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
        @(negedge clk);
        check_bit("ready_for_fuses", ready_for_fuses, 1'b1);
        check_state(BOOT_FUSE);

        for (i = 0; i < FUSE_WORDS; i++) begin
            exp_fuse[i] = lcg_next();
            write_reg(fuse_addr(i), exp_fuse[i], 1'b0);
        end
        for (i = 0; i < FUSE_WORDS; i++) begin
            read_reg(fuse_addr(i), exp_fuse[i]);
        end
        check_fuse_words();
        // index past the bank, read-only status, unmapped offset
        write_reg(fuse_addr(FUSE_WORDS), lcg_next(), 1'b1);
        write_reg(REG_BOOT_STATUS, 32'h7, 1'b1);
        bus_access(1'b0, 8'h60, 32'd0, rd, er);
        check_bit("rsp.err (read 60)", er, 1'b1);
        read_reg(REG_BOOT_STATUS, 32'h1);
        check_fuse_words();

        // fuse done, fsm reaches done one edge after it is registered
        write_reg(REG_FUSE_DONE, 32'h1, 1'b0);
        exp_fuse_done = 1'b1;
        check_state(BOOT_FUSE);
        @(negedge clk);
        check_state(BOOT_DONE);
        check_bit("ready_for_fuses", ready_for_fuses, 1'b0);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        @(negedge clk);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b0);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b0);
        @(negedge clk);
        check_bit("cptra_noncore_rst_b", cptra_noncore_rst_b, 1'b1);
        check_bit("cptra_uc_rst_b", cptra_uc_rst_b, 1'b1);
        read_reg(REG_FUSE_DONE, {31'd0, exp_fuse_done});
        read_reg(REG_BOOT_STATUS, 32'h6);
        // fuse window is closed
        write_reg(fuse_addr(0), lcg_next(), 1'b1);
        check_fuse_words();

        run_fw_reset(FW_RST_WAIT_RESET, 1'b0, MODE_LOCK_FIRST);
        run_fw_reset(8'd3, 1'b1, MODE_LOCK_FIRST);
        run_fw_reset(8'd1, 1'b1, MODE_LOCK_FIRST);
        run_fw_reset(FW_RST_WAIT_RESET, 1'b1, MODE_RELOCK);
        run_fw_reset(8'd0, 1'b1, MODE_POLL);

        $display("Test completed successfully");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_error($sformatf("Timeout: run did not finish within %0d cycles",
                               WATCHDOG_CYCLES));
    end

endmodule

`default_nettype wire

// File: source/soc_ifc_top.sv
/* soc interface top: boot fsm, register block and fuse bank */

`timescale 1ns/10ps
`default_nettype none

module soc_ifc_top #(
    parameter int FUSE_WORDS = 8
) (
    input  logic                        clk,
    input  logic                        cptra_rst_b,
    input  logic                        cptra_pwrgood,
    input  soc_ifc_pkg::soc_ifc_req_t   req,

    output soc_ifc_pkg::soc_ifc_rsp_t   rsp,
    output logic                        ready_for_fuses,
    output logic                        cptra_noncore_rst_b,
    output logic                        cptra_uc_rst_b,
    output logic                        iccm_unlock,
    output logic                        iccm_lock,
    output logic [FUSE_WORDS-1:0][31:0] fuse_words
);

    // register block to fsm
    logic        fuse_done;
    logic        fw_update_rst;
    logic [7:0]  fw_update_rst_wait_cycles;

    // register block to fuse bank
    logic        fuse_wr;
    logic [3:0]  fuse_idx;
    logic [31:0] fuse_wdata;
    logic        fuse_wr_rejected;

    soc_ifc_boot_fsm boot_fsm_inst (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .cptra_pwrgood             (cptra_pwrgood),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .fuse_done                 (fuse_done),
        .ready_for_fuses           (ready_for_fuses),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock)
    );

    soc_ifc_reg_block #(
        .FUSE_WORDS (FUSE_WORDS)
    ) reg_block_inst (
        .clk                       (clk),
        .cptra_rst_b               (cptra_rst_b),
        .req                       (req),
        .ready_for_fuses           (ready_for_fuses),
        .cptra_noncore_rst_b       (cptra_noncore_rst_b),
        .cptra_uc_rst_b            (cptra_uc_rst_b),
        .iccm_unlock               (iccm_unlock),
        .fuse_wr_rejected          (fuse_wr_rejected),
        .fuse_words                (fuse_words),
        .rsp                       (rsp),
        .fuse_done                 (fuse_done),
        .fw_update_rst             (fw_update_rst),
        .fw_update_rst_wait_cycles (fw_update_rst_wait_cycles),
        .iccm_lock                 (iccm_lock),
        .fuse_wr                   (fuse_wr),
        .fuse_idx                  (fuse_idx),
        .fuse_wdata                (fuse_wdata)
    );

    soc_ifc_fuse_bank #(
        .FUSE_WORDS (FUSE_WORDS)
    ) fuse_bank_inst (
        .clk              (clk),
        .cptra_rst_b      (cptra_rst_b),
        .ready_for_fuses  (ready_for_fuses),
        .fuse_wr          (fuse_wr),
        .fuse_idx         (fuse_idx),
        .fuse_wdata       (fuse_wdata),
        .fuse_wr_rejected (fuse_wr_rejected),
        .fuse_words       (fuse_words)
    );

endmodule

`default_nettype wire

// File: source/soc_ifc_fuse_bank.sv
/* fuse word storage, writable only while the boot fsm waits for fuses */

`timescale 1ns/10ps
`default_nettype none

module soc_ifc_fuse_bank #(
    parameter int FUSE_WORDS = 8
) (
    input  logic                        clk,
    input  logic                        cptra_rst_b,
    input  logic                        ready_for_fuses,
    input  logic                        fuse_wr,
    input  logic [3:0]                  fuse_idx,
    input  logic [31:0]                 fuse_wdata,

    output logic                        fuse_wr_rejected,
    output logic [FUSE_WORDS-1:0][31:0] fuse_words
);

    // write is legal only in the fuse window of the boot flow
    // and only for an index that exists
    logic wr_ok;

    assign wr_ok = ready_for_fuses && (int'(fuse_idx) < FUSE_WORDS);

    // same-cycle answer to the register block
    assign fuse_wr_rejected = fuse_wr & ~wr_ok;

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_words <= '0;
        end else if (fuse_wr && wr_ok) begin
            fuse_words[fuse_idx] <= fuse_wdata;
        end
    end

endmodule

`default_nettype wire

// File: source/soc_ifc_reg_block.sv
/* soc register block: address decode, fuse-done, wait-cycles and iccm lock
   registers, fuse write forwarding, firmware-reset pulse and bus responses */

`timescale 1ns/10ps
`default_nettype none

module soc_ifc_reg_block #(
    parameter int FUSE_WORDS = 8
) (
    input  logic                           clk,
    input  logic                           cptra_rst_b,
    input  soc_ifc_pkg::soc_ifc_req_t      req,
    input  logic                           ready_for_fuses,
    input  logic                           cptra_noncore_rst_b,
    input  logic                           cptra_uc_rst_b,
    input  logic                           iccm_unlock,
    input  logic                           fuse_wr_rejected,
    input  logic [FUSE_WORDS-1:0][31:0]    fuse_words,

    output soc_ifc_pkg::soc_ifc_rsp_t      rsp,
    output logic                           fuse_done,
    output logic                           fw_update_rst,
    output logic [7:0]                     fw_update_rst_wait_cycles,
    output logic                           iccm_lock,
    output logic                           fuse_wr,
    output logic [3:0]                     fuse_idx,
    output logic [31:0]                    fuse_wdata
);

    import soc_ifc_pkg::*;

    logic        wr_en;
    // decoded register hits
    logic        hit_fuse;
    logic        hit_fuse_done;
    logic        hit_fw_rst;
    logic        hit_wait;
    logic        hit_lock;
    logic        hit_status;
    logic        fuse_in_range;

    logic [31:0] rdata_nxt;
    logic        err_nxt;

    // registered response
    logic        rsp_valid_q;
    logic        rsp_err_q;
    logic [31:0] rsp_rdata_q;

    assign wr_en = req.valid & req.write;

    // fuse window covers 0x00..0x3c, word aligned
    assign hit_fuse      = (req.addr[7:6] == 2'b00) && (req.addr[1:0] == 2'b00);
    assign hit_fuse_done = (req.addr == REG_FUSE_DONE);
    assign hit_fw_rst    = (req.addr == REG_FW_UPDATE_RST);
    assign hit_wait      = (req.addr == REG_FW_RST_WAIT);
    assign hit_lock      = (req.addr == REG_ICCM_LOCK);
    assign hit_status    = (req.addr == REG_BOOT_STATUS);

    assign fuse_idx      = req.addr[5:2];
    assign fuse_in_range = int'(fuse_idx) < FUSE_WORDS;

    // fuse writes go straight to the bank, which may refuse them
    assign fuse_wr    = wr_en & hit_fuse;
    assign fuse_wdata = req.wdata;

    // read data and error for the current request
    always_comb begin
        rdata_nxt = 32'd0;
        err_nxt   = 1'b0;
        if (hit_fuse) begin
            if (req.write) begin
                err_nxt = fuse_wr_rejected;
            end else if (fuse_in_range) begin
                rdata_nxt = fuse_words[fuse_idx];
            end else begin
                err_nxt = 1'b1;
            end
        end else if (hit_fuse_done) begin
            rdata_nxt = {31'd0, fuse_done};
        end else if (hit_fw_rst) begin
            // write-only pulse, reads as zero
            rdata_nxt = 32'd0;
        end else if (hit_wait) begin
            rdata_nxt = {24'd0, fw_update_rst_wait_cycles};
        end else if (hit_lock) begin
            rdata_nxt = {31'd0, iccm_lock};
        end else if (hit_status) begin
            rdata_nxt = {29'd0, cptra_uc_rst_b, cptra_noncore_rst_b, ready_for_fuses};
            // status is read only
            err_nxt   = req.write;
        end else begin
            err_nxt = 1'b1;
        end
    end

    // control registers
    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            fuse_done                 <= 1'b0;
            fw_update_rst             <= 1'b0;
            fw_update_rst_wait_cycles <= FW_RST_WAIT_RESET;
            iccm_lock                 <= 1'b0;
            rsp_valid_q               <= 1'b0;
        end else begin
            // sticky until reset
            if (wr_en && hit_fuse_done && req.wdata[0]) begin
                fuse_done <= 1'b1;
            end
            // single cycle pulse per write
            fw_update_rst <= wr_en & hit_fw_rst & req.wdata[0];
            if (wr_en && hit_wait) begin
                fw_update_rst_wait_cycles <= req.wdata[7:0];
            end
            // unlock pulse wins over a same-cycle set
            if (iccm_unlock) begin
                iccm_lock <= 1'b0;
            end else if (wr_en && hit_lock && req.wdata[0]) begin
                iccm_lock <= 1'b1;
            end
            rsp_valid_q <= req.valid;
        end
    end

    // response payload only updates on a request
    always_ff @(posedge clk) begin
        if (req.valid) begin
            rsp_err_q   <= err_nxt;
            rsp_rdata_q <= rdata_nxt;
        end
    end

    always_comb begin
        rsp.valid = rsp_valid_q;
        rsp.err   = rsp_err_q;
        rsp.rdata = rsp_rdata_q;
    end

endmodule

`default_nettype wire

// File: source/soc_ifc_boot_fsm.sv
/* boot fsm: power-good and fuse-done sequencing, non-core and core reset
   generation, firmware-update reset wait timer and iccm unlock pulse */

`timescale 1ns/10ps
`default_nettype none

module soc_ifc_boot_fsm (
    input  logic       clk,
    input  logic       cptra_rst_b,
    input  logic       cptra_pwrgood,
    input  logic       fw_update_rst,
    input  logic [7:0] fw_update_rst_wait_cycles,
    input  logic       fuse_done,

    output logic       ready_for_fuses,
    // global reset for everything outside the core
    output logic       cptra_noncore_rst_b,
    // global plus firmware-update reset, core only
    output logic       cptra_uc_rst_b,
    output logic       iccm_unlock
);

    import soc_ifc_pkg::*;

    boot_fsm_state_e state_ps;
    boot_fsm_state_e state_ns;

    // release enable for the non-core path, only while in done
    logic propagate_rst_en;
    // core reset request from the fsm, low holds the core
    logic fsm_uc_rst_b;
    logic fsm_iccm_unlock;

    // first stage of the registered reset release
    logic noncore_rst_stage;
    logic uc_rst_stage;

    // wait timer, loads in idle/fuse/done, counts down in fw_rst/wait
    logic [7:0] wait_count;
    logic       wait_decr;

    always_comb begin
        state_ns         = state_ps;
        ready_for_fuses  = 1'b0;
        propagate_rst_en = 1'b0;
        fsm_uc_rst_b     = 1'b0;
        fsm_iccm_unlock  = 1'b0;
        wait_decr        = 1'b0;

        unique case (state_ps)
            BOOT_IDLE: begin
                // soc signals power good
                if (cptra_pwrgood) begin
                    state_ns = BOOT_FUSE;
                end
            end
            BOOT_FUSE: begin
                // soc may load fuses here
                ready_for_fuses = 1'b1;
                if (fuse_done) begin
                    state_ns = BOOT_DONE;
                end
            end
            BOOT_FW_RST: begin
                // core goes back into reset, timer starts
                wait_decr = 1'b1;
                state_ns  = BOOT_WAIT;
            end
            BOOT_WAIT: begin
                wait_decr = 1'b1;
                // unlock iccm only as the wait ends
                // so the core never runs with an open iccm mid-update
                if (wait_count == 8'd0) begin
                    state_ns        = BOOT_DONE;
                    fsm_iccm_unlock = 1'b1;
                end
            end
            BOOT_DONE: begin
                propagate_rst_en = 1'b1;
                fsm_uc_rst_b     = 1'b1;
                // fw update pulse is only honored here
                if (fw_update_rst) begin
                    state_ns = BOOT_FW_RST;
                end
            end
            default: begin
                state_ns = BOOT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge cptra_rst_b) begin
        if (!cptra_rst_b) begin
            state_ps            <= BOOT_IDLE;
            noncore_rst_stage   <= 1'b0;
            uc_rst_stage        <= 1'b0;
            cptra_noncore_rst_b <= 1'b0;
            cptra_uc_rst_b      <= 1'b0;
            wait_count          <= 8'd0;
            iccm_unlock         <= 1'b0;
        end else begin
            state_ps <= state_ns;

            // non-core release is sticky once done is reached
            noncore_rst_stage   <= propagate_rst_en | noncore_rst_stage;
            cptra_noncore_rst_b <= noncore_rst_stage;

            // core release needs global release and no fw reset request
            uc_rst_stage   <= fsm_uc_rst_b;
            cptra_uc_rst_b <= noncore_rst_stage & fsm_uc_rst_b & uc_rst_stage;

            // zero wraps to 255, so a wait of 0 acts as 256
            if (wait_decr) begin
                wait_count <= wait_count - 8'd1;
            end else begin
                wait_count <= fw_update_rst_wait_cycles;
            end

            iccm_unlock <= fsm_iccm_unlock;
        end
    end

endmodule

`default_nettype wire

// File: source/soc_ifc_pkg.sv
/* shared soc interface definitions: boot fsm state encoding,
   register bus request/response structs, register offsets and reset values */

`default_nettype none

package soc_ifc_pkg;

    // boot fsm states
    // fw_rst and wait only reachable from done
    typedef enum logic [2:0] {
        BOOT_IDLE   = 3'd0,
        BOOT_FUSE   = 3'd1,
        BOOT_FW_RST = 3'd2,
        BOOT_WAIT   = 3'd3,
        BOOT_DONE   = 3'd4
    } boot_fsm_state_e;

    // soc register bus request, one strobe per access
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } soc_ifc_req_t;

    // response comes back one cycle after the request
    typedef struct packed {
        logic        valid;
        logic        err;
        logic [31:0] rdata;
    } soc_ifc_rsp_t;

    // register byte offsets
    // fuse word i lives at REG_FUSE_BASE + 4*i
    localparam logic [7:0] REG_FUSE_BASE     = 8'h00;
    localparam logic [7:0] REG_FUSE_DONE     = 8'h40;
    localparam logic [7:0] REG_FW_UPDATE_RST = 8'h44;
    localparam logic [7:0] REG_FW_RST_WAIT   = 8'h48;
    localparam logic [7:0] REG_ICCM_LOCK     = 8'h4C;
    localparam logic [7:0] REG_BOOT_STATUS   = 8'h50;

    // default core reset hold time in cycles
    localparam logic [7:0] FW_RST_WAIT_RESET = 8'h06;

endpackage

`default_nettype wire
